// File: Makefile
VERILATOR       ?= verilator
TOP             ?= pkt_digest_tb
FILELIST        ?= project.f
OBJ_DIR         ?= obj_dir
LOG             ?= sim.log
PASS_MSG        ?= Simulation passed
VERILATOR_FLAGS ?= --binary --timing --timescale 1ns/1ns -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
src/digest_pkg.sv
src/skid_buffer.sv
src/crc_lane.sv
src/sum_lane.sv
src/summary_join.sv
src/pkt_digest_top.sv
verif/pkt_digest_tb.sv

// File: src/crc_lane.sv
`timescale 1ns/1ns
`default_nettype none

module crc_lane #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  beat_fire,
  input  logic                  beat_last,
  input  logic [DATA_WIDTH-1:0] beat_data,
  output logic                  crc_done,
  output logic [7:0]            crc_value
);

  logic [7:0] crc_reg;
  logic [7:0] crc_next;

  // Bitwise fold of one beat, MSB first.
  always_comb begin
    logic feedback;
    crc_next = crc_reg;
    for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
      feedback = crc_next[7] ^ beat_data[i];
      crc_next = {crc_next[6:0], 1'b0} ^ (feedback ? digest_pkg::CRC_POLY : 8'h00);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crc_reg  <= digest_pkg::CRC_INIT;
      crc_done <= 1'b0;
    end else begin
      crc_done <= beat_fire && beat_last;  // One-cycle pulse.
      if (beat_fire) begin
        crc_reg <= beat_last ? digest_pkg::CRC_INIT : crc_next;
      end
    end
  end

  // Final value, valid while crc_done is high and until the next packet ends.
  always_ff @(posedge clk) begin
    if (beat_fire && beat_last) begin
      crc_value <= crc_next;
    end
  end

endmodule

`default_nettype wire

// File: src/digest_pkg.sv
`default_nettype none

package digest_pkg;

  // CRC-8 generator, MSB first, no reflection and no final XOR.
  localparam logic [7:0] CRC_POLY = 8'h07;

  // Running CRC start value for every packet.
  localparam logic [7:0] CRC_INIT = 8'h00;

  // Beat counter and record length width.
  localparam int LEN_WIDTH = 8;

  typedef enum logic {
    JOIN_IDLE = 1'b0,  // Accepting beats.
    JOIN_HOLD = 1'b1   // Record pending.
  } join_state_e;

endpackage

`default_nettype wire

// File: src/pkt_digest_top.sv
`timescale 1ns/1ns
`default_nettype none

module pkt_digest_top #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              s_valid,
  output logic                              s_ready,
  input  logic [DATA_WIDTH-1:0]             s_data,
  input  logic                              s_last,
  output logic                              m_valid,
  input  logic                              m_ready,
  output logic [digest_pkg::LEN_WIDTH-1:0]  m_len,
  output logic [DATA_WIDTH-1:0]             m_sum,
  output logic [7:0]                        m_crc
);

  // Record is {len, sum, crc}.
  localparam int REC_WIDTH = digest_pkg::LEN_WIDTH + DATA_WIDTH + 8;

  logic                             beat_valid;
  logic                             beat_ready;
  logic                             beat_fire;
  logic [DATA_WIDTH-1:0]            beat_data;
  logic                             beat_last;
  logic                             crc_done;
  logic [7:0]                       crc_value;
  logic                             sum_done;
  logic [DATA_WIDTH-1:0]            sum_value;
  logic [digest_pkg::LEN_WIDTH-1:0] len_value;
  logic                             rec_valid;
  logic                             rec_ready;
  logic [digest_pkg::LEN_WIDTH-1:0] rec_len;
  logic [DATA_WIDTH-1:0]            rec_sum;
  logic [7:0]                       rec_crc;

  skid_buffer #(
    .DATA_WIDTH(DATA_WIDTH + 1),
    .OPT_OUTREG(0)
  ) in_buf (
    .clk    (clk),
    .rst_n  (rst_n),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .s_data ({s_last, s_data}),
    .m_valid(beat_valid),
    .m_ready(beat_ready),
    .m_data ({beat_last, beat_data})
  );

  crc_lane #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_crc_lane (
    .clk      (clk),
    .rst_n    (rst_n),
    .beat_fire(beat_fire),
    .beat_last(beat_last),
    .beat_data(beat_data),
    .crc_done (crc_done),
    .crc_value(crc_value)
  );

  sum_lane #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_sum_lane (
    .clk      (clk),
    .rst_n    (rst_n),
    .beat_fire(beat_fire),
    .beat_last(beat_last),
    .beat_data(beat_data),
    .sum_done (sum_done),
    .sum_value(sum_value),
    .len_value(len_value)
  );

  summary_join #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_summary_join (
    .clk       (clk),
    .rst_n     (rst_n),
    .beat_valid(beat_valid),
    .beat_last (beat_last),
    .beat_ready(beat_ready),
    .beat_fire (beat_fire),
    .crc_done  (crc_done),
    .sum_done  (sum_done),
    .crc_value (crc_value),
    .sum_value (sum_value),
    .len_value (len_value),
    .rec_valid (rec_valid),
    .rec_ready (rec_ready),
    .rec_len   (rec_len),
    .rec_sum   (rec_sum),
    .rec_crc   (rec_crc)
  );

  skid_buffer #(
    .DATA_WIDTH(REC_WIDTH),
    .OPT_OUTREG(1)
  ) out_buf (
    .clk    (clk),
    .rst_n  (rst_n),
    .s_valid(rec_valid),
    .s_ready(rec_ready),
    .s_data ({rec_len, rec_sum, rec_crc}),
    .m_valid(m_valid),
    .m_ready(m_ready),
    .m_data ({m_len, m_sum, m_crc})
  );

endmodule

`default_nettype wire

// File: src/skid_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module skid_buffer #(
  parameter int DATA_WIDTH = 8,
  parameter bit OPT_OUTREG = 0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  s_valid,
  output logic                  s_ready,
  input  logic [DATA_WIDTH-1:0] s_data,
  output logic                  m_valid,
  input  logic                  m_ready,
  output logic [DATA_WIDTH-1:0] m_data
);

  logic                  skid_valid;
  logic [DATA_WIDTH-1:0] skid_data;

  assign s_ready = !skid_valid;  // Registered, so no path from m_ready.

  // Skid entry catches a beat accepted while the output stalls.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_valid <= 1'b0;
    end else if (s_valid && s_ready && m_valid && !m_ready) begin
      skid_valid <= 1'b1;
    end else if (m_ready) begin
      skid_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s_ready) begin
      skid_data <= s_data;  // Only kept once skid_valid sets.
    end
  end

  if (OPT_OUTREG) begin : g_outreg
    logic                  out_valid;
    logic [DATA_WIDTH-1:0] out_data;

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        out_valid <= 1'b0;
      end else if (!out_valid || m_ready) begin
        out_valid <= s_valid || skid_valid;
      end
    end

    // Skid entry drains first to keep order.
    always_ff @(posedge clk) begin
      if (!out_valid || m_ready) begin
        out_data <= skid_valid ? skid_data : s_data;
      end
    end

    assign m_valid = out_valid;
    assign m_data  = out_data;
  end else begin : g_comb
    assign m_valid = s_valid || skid_valid;  // Empty buffer passes through.
    assign m_data  = skid_valid ? skid_data : s_data;
  end

endmodule

`default_nettype wire

// File: src/sum_lane.sv
`timescale 1ns/1ns
`default_nettype none

module sum_lane #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              beat_fire,
  input  logic                              beat_last,
  input  logic [DATA_WIDTH-1:0]             beat_data,
  output logic                              sum_done,
  output logic [DATA_WIDTH-1:0]             sum_value,
  output logic [digest_pkg::LEN_WIDTH-1:0]  len_value
);

  localparam logic [digest_pkg::LEN_WIDTH-1:0] CNT_ONE = 1;

  logic [DATA_WIDTH-1:0]            sum_acc;
  logic [digest_pkg::LEN_WIDTH-1:0] cnt_acc;
  logic [DATA_WIDTH-1:0]            sum_next;
  logic [digest_pkg::LEN_WIDTH-1:0] cnt_next;

  assign sum_next = sum_acc + beat_data;  // Wraps modulo 2^DATA_WIDTH.
  assign cnt_next = cnt_acc + CNT_ONE;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_acc  <= '0;
      cnt_acc  <= '0;
      sum_done <= 1'b0;
    end else begin
      sum_done <= beat_fire && beat_last;
      if (beat_fire) begin
        sum_acc <= beat_last ? '0 : sum_next;  // Clear for next packet.
        cnt_acc <= beat_last ? '0 : cnt_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_fire && beat_last) begin
      sum_value <= sum_next;
      len_value <= cnt_next;
    end
  end

endmodule

`default_nettype wire

// File: src/summary_join.sv
`timescale 1ns/1ns
`default_nettype none

module summary_join #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              beat_valid,
  input  logic                              beat_last,
  output logic                              beat_ready,
  output logic                              beat_fire,
  input  logic                              crc_done,
  input  logic                              sum_done,
  input  logic [7:0]                        crc_value,
  input  logic [DATA_WIDTH-1:0]             sum_value,
  input  logic [digest_pkg::LEN_WIDTH-1:0]  len_value,
  output logic                              rec_valid,
  input  logic                              rec_ready,
  output logic [digest_pkg::LEN_WIDTH-1:0]  rec_len,
  output logic [DATA_WIDTH-1:0]             rec_sum,
  output logic [7:0]                        rec_crc
);

  digest_pkg::join_state_e state;

  // Beats stall from the end of a packet until its record is handed off.
  assign beat_ready = (state == digest_pkg::JOIN_IDLE);
  assign beat_fire  = beat_valid && beat_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= digest_pkg::JOIN_IDLE;
    end else begin
      case (state)
        digest_pkg::JOIN_IDLE: begin
          if (beat_fire && beat_last) begin
            state <= digest_pkg::JOIN_HOLD;
          end
        end
        digest_pkg::JOIN_HOLD: begin
          if (rec_valid && rec_ready) begin
            state <= digest_pkg::JOIN_IDLE;  // Record left for out_buf.
          end
        end
        default: state <= digest_pkg::JOIN_IDLE;
      endcase
    end
  end

  // Lane pulses always coincide.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rec_valid <= 1'b0;
    end else if (crc_done && sum_done) begin
      rec_valid <= 1'b1;
    end else if (rec_ready) begin
      rec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (crc_done && sum_done) begin
      rec_len <= len_value;
      rec_sum <= sum_value;
      rec_crc <= crc_value;
    end
  end

endmodule

`default_nettype wire

// File: verif/pkt_digest_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pkt_digest_tb;

  localparam int CLK_PERIOD     = 8;
  localparam int STALL_PACKETS  = 6;
  localparam int STALL_BEATS    = 5;
  localparam int STALL_CYCLES   = 200;
  localparam int RAND_PACKETS   = 200;
  localparam int RAND_MAX_BEATS = 20;
  localparam int RAND_MAX_GAP   = 3;
  localparam int LONG_BEATS     = 255;
  localparam int QUIET_CYCLES   = 8;
  localparam int TOTAL_BEATS    = 1 + 42 + STALL_PACKETS * STALL_BEATS
                                  + RAND_PACKETS * RAND_MAX_BEATS + LONG_BEATS;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_BEATS + 500;

  localparam int READY_HIGH   = 0;
  localparam int READY_LOW    = 1;
  localparam int READY_RANDOM = 2;

  logic       clk     = 1'b0;
  logic       rst_n   = 1'b0;
  logic       s_valid = 1'b0;
  logic       s_ready;
  logic [7:0] s_data  = 8'h00;
  logic       s_last  = 1'b0;
  logic       m_valid;
  logic       m_ready = 1'b0;
  logic [7:0] m_len;
  logic [7:0] m_sum;
  logic [7:0] m_crc;

  integer      seed       = 64319;
  integer      ready_seed = 64319;
  int          ready_mode = READY_HIGH;
  int          cycle_count = 0;
  logic        saw_stall = 1'b0;
  logic [7:0]  pkt_q[$];  // Packet being sent.
  logic [23:0] exp_q[$];  // Expected {len, sum, crc} records.
  int          lengths[4] = '{3, 7, 12, 20};

  pkt_digest_top #(
    .DATA_WIDTH(8)
  ) u_pkt_digest_top (
    .clk    (clk),
    .rst_n  (rst_n),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .s_data (s_data),
    .s_last (s_last),
    .m_valid(m_valid),
    .m_ready(m_ready),
    .m_len  (m_len),
    .m_sum  (m_sum),
    .m_crc  (m_crc)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Length, byte sum and CRC-8 (poly 0x07, init 0x00) of the packet in pkt_q.
  function automatic logic [23:0] reference_record();
    logic [7:0] crc;
    logic [7:0] sum;
    logic [7:0] len;
    crc = 8'h00;
    sum = 8'h00;
    len = 8'h00;
    foreach (pkt_q[i]) begin
      sum = sum + pkt_q[i];
      len = len + 8'd1;
      crc = crc ^ pkt_q[i];  // Byte enters at the top.
      repeat (8) begin
        if (crc[7]) begin
          crc = {crc[6:0], 1'b0} ^ 8'h07;
        end else begin
          crc = {crc[6:0], 1'b0};
        end
      end
    end
    return {len, sum, crc};
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fill_random(input int len);
    pkt_q.delete();
    repeat (len) pkt_q.push_back(8'($random(seed)));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      s_valid <= 1'b0;
    end
  endtask

  // Returns once the beat is sure to transfer on the coming edge.
  task automatic send_beat(input logic [7:0] data, input logic last);
    @(posedge clk);
    s_valid <= 1'b1;
    s_data  <= data;
    s_last  <= last;
    @(negedge clk);
    while (!s_ready) @(negedge clk);
  endtask

  task automatic send_packet(input int gap_max);
    exp_q.push_back(reference_record());
    foreach (pkt_q[i]) begin
      if (gap_max > 0) begin
        idle_cycles(int'($unsigned($random(seed)) % (gap_max + 1)));
      end
      send_beat(pkt_q[i], i == pkt_q.size() - 1);
    end
  endtask

  task automatic drain_records();
    idle_cycles(1);
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  always @(posedge clk) begin
    if (ready_mode == READY_LOW) begin
      m_ready <= 1'b0;
    end else if (ready_mode == READY_RANDOM) begin
      m_ready <= ($random(ready_seed) % 4) != 0;  // Ready about 3 cycles in 4.
    end else begin
      m_ready <= 1'b1;
    end
  end

  // Output transfer completes on the next rising edge.
  always @(negedge clk) begin
    logic [23:0] expected;
    if (rst_n && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        $display("Output record arrived at %0t ns with no packet outstanding", $time);
        $display("Simulation failed");
        $fatal(1, "extra record");
      end else begin
        expected = exp_q.pop_front();
        check_value(32'(m_len), 32'(expected[23:16]), "m_len");
        check_value(32'(m_sum), 32'(expected[15:8]), "m_sum");
        check_value(32'(m_crc), 32'(expected[7:0]), "m_crc");
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    int len;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value(32'(s_ready), 32'd1, "s_ready after reset");
    check_value(32'(m_valid), 32'd0, "m_valid after reset");

    pkt_q.delete();
    pkt_q.push_back(8'hA5);
    send_packet(0);
    foreach (lengths[i]) begin  // Back to back, no gaps.
      fill_random(lengths[i]);
      send_packet(0);
    end
    drain_records();

    ready_mode = READY_LOW;
    fork
      begin
        repeat (STALL_CYCLES) begin
          @(negedge clk);
          if (!s_ready) saw_stall = 1'b1;
        end
        ready_mode = READY_HIGH;
      end
      begin
        repeat (STALL_PACKETS) begin
          fill_random(STALL_BEATS);
          send_packet(0);
        end
      end
    join
    check_value(32'(saw_stall), 32'd1, "s_ready drop under back-pressure");
    drain_records();

    ready_mode = READY_RANDOM;
    repeat (RAND_PACKETS) begin
      len = 1 + int'($unsigned($random(seed)) % RAND_MAX_BEATS);
      fill_random(len);
      send_packet(RAND_MAX_GAP);
    end
    drain_records();

    ready_mode = READY_HIGH;
    fill_random(LONG_BEATS);  // Count reaches 255.
    send_packet(0);
    drain_records();

    idle_cycles(QUIET_CYCLES);  // A late duplicate record would show here.
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
